// ==== cacheL1_consts.svh ====
`ifndef cacheL1ConstsSvh
`define cacheL1ConstsSvh

////////////////////////////////////////////////////////////////////////////
// Address geometry for the 16KB 4-way cache
////////////////////////////////////////////////////////////////////////////

`define addrWidth      32     // CPU byte address
`define wordWidth      32     // Bus word
`define tagWidth       20     // Upper address bits kept per way
`define indexWidth     8      // 256 sets
`define offsetWidth    4      // 16 bytes per line

// Organization
`define numWays        4      // Ways per set
`define wordsPerLine   4      // 32-bit words in one line

////////////////////////////////////////////////////////////////////////////
// Operation codes on the opReq path
////////////////////////////////////////////////////////////////////////////

`define opCodeWidth    4
`define opInvalLine    3      // Drop the addressed line
`define opInvalAll     4      // Flush every valid bit

`endif

// ==== busPkg.sv ====
`include "cacheL1_consts.svh"

// Types seen on the CPU and memory buses
package busPkg;

	typedef logic [`wordWidth-1:0] wordT;    // Data word
	typedef logic [`addrWidth-1:0] addrT;    // Byte address

	// Opcodes on the opReq path, unknown values are acknowledged only
	typedef enum logic [`opCodeWidth-1:0]
	{
		opNone      = `opCodeWidth'(0),
		opInvalLine = `opCodeWidth'(`opInvalLine),
		opInvalAll  = `opCodeWidth'(`opInvalAll)
	} cacheOpT;

endpackage

// ==== cachePkg.sv ====
`include "cacheL1_consts.svh"

// Types that describe how the cache is organized
package cachePkg;

	typedef logic [`tagWidth-1:0]   tagT;      // Stored tag
	typedef logic [`indexWidth-1:0] indexT;    // Set number

	// Word within a line and way within a set
	typedef logic [$clog2(`wordsPerLine)-1:0] wordSelT;
	typedef logic [$clog2(`numWays)-1:0]      wayT;

	// One bit per way, used for valid and recently-used state
	typedef logic [`numWays-1:0] wayVecT;

	// Byte address split into its cache fields, MSB first
	typedef struct packed
	{
		tagT     tag;                                              // [31:12]
		indexT   index;                                            // [11:4]
		wordSelT wordSel;                                          // [3:2]
		logic [`offsetWidth-$clog2(`wordsPerLine)-1:0] byteOff;    // [1:0]
	} cacheAddrT;

endpackage

// ==== cacheIfc.sv ====
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Controller to tag store
////////////////////////////////////////////////////////////////////////////

interface tagPortIf import cachePkg::*; ();
	indexT  index;            // Set under lookup
	tagT    tag;              // Tag to compare or to store on fill
	logic   touch;            // Recently-used update for way
	logic   fill;             // Write tag, set valid
	logic   invalidate;       // Clear valid of way
	logic   invalidateAll;    // Clear every valid bit
	wayT    way;              // Target of the strobes above
	logic   hit;
	wayT    hitWay;
	wayT    victimWay;

	modport ctrl (output index, tag, touch, fill, invalidate, invalidateAll, way,
		input hit, hitWay, victimWay);
	modport store (input index, tag, touch, fill, invalidate, invalidateAll, way,
		output hit, hitWay, victimWay);
endinterface

////////////////////////////////////////////////////////////////////////////
// Controller to data store
////////////////////////////////////////////////////////////////////////////

interface dataPortIf import cachePkg::*, busPkg::*; ();
	indexT   index;
	wayT     way;
	wordSelT wordSel;
	logic    writeEn;     // One word replaced at the edge
	wordT    wrData;
	wordT    rdData;      // Word addressed one cycle earlier

	modport ctrl (output index, way, wordSel, writeEn, wrData, input rdData);
	modport store (input index, way, wordSel, writeEn, wrData, output rdData);
endinterface

// ==== cacheTagStore.sv ====
`timescale 1ns/1ps
`include "cacheL1_consts.svh"

module cacheTagStore import cachePkg::*; (
	input logic clk,
	input logic rstN,
	tagPortIf.store tagPort
);

	localparam int numSets = 1 << `indexWidth;

	wayVecT validQ [numSets];              // Valid bit per way
	wayVecT ruQ [numSets];                 // Recently-used bit per way
	tagT    tagQ [numSets][`numWays];

	wayVecT setValid;                      // State of the presented set
	wayVecT setRu;
	wayVecT matchVec;                      // Valid and tag equal, per way

	// Mark way as used, start over when the set would be all ones
	function automatic wayVecT nextRu(wayVecT ru, wayT way);
		wayVecT touched;
		touched = ru | (wayVecT'(1) << way);
		if (&touched)
			touched = wayVecT'(1) << way;    // Only the touched way survives
		return touched;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Lookup, all combinational
	////////////////////////////////////////////////////////////////////////////

	assign setValid = validQ[tagPort.index];
	assign setRu = ruQ[tagPort.index];

	always_comb
	begin
		for (int w = 0; w < `numWays; w++)
			matchVec[w] = setValid[w] && (tagQ[tagPort.index][w] == tagPort.tag);
	end

	assign tagPort.hit = |matchVec;

	// Lowest matching way, walk from the top so the lowest wins
	always_comb
	begin
		tagPort.hitWay = '0;
		for (int w = `numWays - 1; w >= 0; w--)
		begin
			if (matchVec[w])
				tagPort.hitWay = wayT'(w);
		end
	end

	// Victim is first invalid way, else first way not recently used
	always_comb
	begin
		tagPort.victimWay = '0;
		if (&setValid)
		begin
			for (int w = `numWays - 1; w >= 0; w--)
			begin
				if (!setRu[w])
					tagPort.victimWay = wayT'(w);
			end
		end
		else
		begin
			for (int w = `numWays - 1; w >= 0; w--)
			begin
				if (!setValid[w])
					tagPort.victimWay = wayT'(w);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Updates at the edge
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int s = 0; s < numSets; s++)
			begin
				validQ[s] <= '0;
				ruQ[s] <= '0;
			end
		end
		else if (tagPort.invalidateAll)
		begin
			for (int s = 0; s < numSets; s++)
				validQ[s] <= '0;               // Recently-used bits stay
		end
		else
		begin
			if (tagPort.fill)
				validQ[tagPort.index][tagPort.way] <= 1'b1;
			else if (tagPort.invalidate)
				validQ[tagPort.index][tagPort.way] <= 1'b0;
			if (tagPort.touch || tagPort.fill)
				ruQ[tagPort.index] <= nextRu(ruQ[tagPort.index], tagPort.way);
		end
	end

	// Tag written only on fill
	always_ff @(posedge clk)
	begin
		if (tagPort.fill)
			tagQ[tagPort.index][tagPort.way] <= tagPort.tag;
	end

endmodule

// ==== cacheDataStore.sv ====
`timescale 1ns/1ps
`include "cacheL1_consts.svh"

module cacheDataStore import busPkg::*; (
	input logic clk,
	dataPortIf.store dataPort
);

	localparam int numSets = 1 << `indexWidth;

	// 256 sets x 4 ways x 4 words, 16KB
	wordT lineMem [numSets][`numWays][`wordsPerLine];

	////////////////////////////////////////////////////////////////////////////
	// Single word write
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (dataPort.writeEn)
			lineMem[dataPort.index][dataPort.way][dataPort.wordSel] <= dataPort.wrData;
	end

	////////////////////////////////////////////////////////////////////////////
	// Registered read
	////////////////////////////////////////////////////////////////////////////

	// Word shows up one cycle after index, way and wordSel
	always_ff @(posedge clk)
	begin
		dataPort.rdData <= lineMem[dataPort.index][dataPort.way][dataPort.wordSel];
	end

endmodule

// ==== cacheController.sv ====
`timescale 1ns/1ps
`include "cacheL1_consts.svh"

module cacheController import cachePkg::*, busPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	input  logic    cpuReq,
	input  logic    cpuWe,
	input  addrT    cpuAddr,
	input  wordT    cpuWrData,
	output wordT    cpuRdData,
	output logic    cpuAck,
	input  logic    opReq,
	input  cacheOpT opCode,
	output logic    memReq,
	output logic    memWe,
	output addrT    memAddr,
	output wordT    memWrData,
	input  wordT    memRdData,
	input  logic    memAck,
	tagPortIf.ctrl  tagPort,
	dataPortIf.ctrl dataPort
);

	typedef enum logic [2:0]
	{
		idle, lookup, readWord, fillReq, fillWait, writeReq, writeWait, ack
	} stateT;

	stateT     state;
	cacheAddrT reqAddr;      // Latched request
	wordT      reqData;
	cacheOpT   reqOp;
	logic      reqWe;
	logic      reqIsOp;      // Came in on opReq
	wayT       fillWay;      // Victim picked at lookup
	wordSelT   wordCnt;      // Fill beat
	cacheAddrT fillAddr;

	logic inLookup;
	logic memBeat;           // Fill word arriving this edge
	logic lastBeat;

	assign inLookup = (state == lookup);
	assign memBeat = (state == fillWait) && memAck;
	assign lastBeat = memBeat && (wordCnt == wordSelT'(`wordsPerLine - 1));

	// Line base plus current beat
	always_comb
	begin
		fillAddr = reqAddr;
		fillAddr.wordSel = wordCnt;
		fillAddr.byteOff = '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Tag and data store strobes
	////////////////////////////////////////////////////////////////////////////

	assign tagPort.index = reqAddr.index;
	assign tagPort.tag = reqAddr.tag;
	assign tagPort.way = inLookup ? tagPort.hitWay : fillWay;
	assign tagPort.touch = (inLookup && !reqIsOp && tagPort.hit) || lastBeat;
	assign tagPort.fill = lastBeat;                    // Whole line present
	assign tagPort.invalidate = inLookup && reqIsOp && (reqOp == opInvalLine)
		&& tagPort.hit;                                // Misses leave the set alone
	assign tagPort.invalidateAll = inLookup && reqIsOp && (reqOp == opInvalAll);

	assign dataPort.index = reqAddr.index;
	assign dataPort.way = inLookup ? tagPort.hitWay : fillWay;
	assign dataPort.wordSel = (state == fillWait) ? wordCnt : reqAddr.wordSel;
	assign dataPort.writeEn = memBeat || (inLookup && !reqIsOp && reqWe && tagPort.hit);
	assign dataPort.wrData = (state == fillWait) ? memRdData : reqData;

	////////////////////////////////////////////////////////////////////////////
	// Request FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= idle;
			cpuAck <= 1'b0;
			cpuRdData <= '0;
			memReq <= 1'b0;
			memWe <= 1'b0;
			wordCnt <= '0;
			reqWe <= 1'b0;
			reqIsOp <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (cpuReq || opReq)
					begin
						reqWe <= cpuWe;
						reqIsOp <= opReq;             // Opcode wins if both are up
						state <= lookup;
					end
				lookup:
					if (reqIsOp)
						state <= ack;                 // Strobes fired this cycle
					else if (reqWe)
						state <= writeReq;            // Write-through, hit or miss
					else if (tagPort.hit)
						state <= readWord;
					else
					begin
						wordCnt <= '0;
						state <= fillReq;
					end
				readWord:
				begin
					cpuRdData <= dataPort.rdData;
					state <= ack;
				end
				fillReq:
					if (!memAck)                      // Previous access fully closed
					begin
						memReq <= 1'b1;
						memWe <= 1'b0;
						state <= fillWait;
					end
				fillWait:
					if (memAck)
					begin
						memReq <= 1'b0;
						if (wordCnt == reqAddr.wordSel)
							cpuRdData <= memRdData;   // Requested word straight from the bus
						wordCnt <= wordCnt + 1'b1;
						state <= lastBeat ? ack : fillReq;
					end
				writeReq:
					if (!memAck)
					begin
						memReq <= 1'b1;
						memWe <= 1'b1;
						state <= writeWait;
					end
				writeWait:
					if (memAck)
					begin
						memReq <= 1'b0;
						memWe <= 1'b0;
						state <= ack;
					end
				ack:
					if (!cpuAck)
						cpuAck <= 1'b1;
					else if (!cpuReq && !opReq)
					begin
						cpuAck <= 1'b0;               // Four-phase close
						state <= idle;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Request payload and memory address/data
	always_ff @(posedge clk)
	begin
		if ((state == idle) && (cpuReq || opReq))
		begin
			reqAddr <= cpuAddr;
			reqData <= cpuWrData;
			reqOp <= opCode;
		end
		if (inLookup)
			fillWay <= tagPort.victimWay;
		if (state == fillReq)
			memAddr <= fillAddr;
		else if (state == writeReq)
		begin
			memAddr <= reqAddr;
			memWrData <= reqData;
		end
	end

endmodule

// ==== cacheL1.sv ====
`timescale 1ns/1ps

module cacheL1 import busPkg::*; (
	input  logic    clk,
	input  logic    rstN,
	// CPU side
	input  logic    cpuReq,
	input  logic    cpuWe,
	input  addrT    cpuAddr,
	input  wordT    cpuWrData,
	output wordT    cpuRdData,
	output logic    cpuAck,
	input  logic    opReq,
	input  cacheOpT opCode,
	// Memory side
	output logic    memReq,
	output logic    memWe,
	output addrT    memAddr,
	output wordT    memWrData,
	input  wordT    memRdData,
	input  logic    memAck
);

	tagPortIf tagPort ();
	dataPortIf dataPort ();

	cacheController controller (
		.clk       (clk),
		.rstN      (rstN),
		.cpuReq    (cpuReq),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.cpuAck    (cpuAck),
		.opReq     (opReq),
		.opCode    (opCode),
		.memReq    (memReq),
		.memWe     (memWe),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memRdData (memRdData),
		.memAck    (memAck),
		.tagPort   (tagPort.ctrl),
		.dataPort  (dataPort.ctrl)
	);

	// Tags and lines side by side
	cacheTagStore tagStore (
		.clk     (clk),
		.rstN    (rstN),
		.tagPort (tagPort.store)
	);

	cacheDataStore dataStore (
		.clk      (clk),
		.dataPort (dataPort.store)
	);

endmodule

// ==== cacheL1_tb.sv ====
`timescale 1ns/1ps
`include "cacheL1_consts.svh"

module cacheL1_tb import cachePkg::*, busPkg::*; ();

	localparam int numSets = 1 << `indexWidth;
	localparam int ackTimeout = 200;            // Cycles per handshake phase
	localparam wordT fillPattern = 32'h5A3C_96E1;

	logic    clk;
	logic    rstN;
	logic    cpuReq;
	logic    cpuWe;
	addrT    cpuAddr;
	wordT    cpuWrData;
	wordT    cpuRdData;
	logic    cpuAck;
	logic    opReq;
	cacheOpT opCode;
	logic    memReq;
	logic    memWe;
	addrT    memAddr;
	wordT    memWrData;
	wordT    memRdData;
	logic    memAck;

	integer seed = 32'h7b2c1ce1;                // Memory latency stream

	// Memory model state
	wordT memWords [addrT];                    // Written words only
	addrT readLog [$];                         // Read addresses of the current request
	addrT lastWrAddr;
	wordT lastWrData;
	int   memReads;
	int   memWrites;

	// Reference model of the tag side
	bit  refValid [numSets][`numWays];
	tagT refTag [numSets][`numWays];
	bit  refUsed [numSets][`numWays];

	cacheL1 u_cacheL1 (
		.clk       (clk),
		.rstN      (rstN),
		.cpuReq    (cpuReq),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.cpuAck    (cpuAck),
		.opReq     (opReq),
		.opCode    (opCode),
		.memReq    (memReq),
		.memWe     (memWe),
		.memAddr   (memAddr),
		.memWrData (memWrData),
		.memRdData (memRdData),
		.memAck    (memAck)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;                 // 4 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic abortRun();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkWord(string name, wordT expected, wordT actual);
		if (expected !== actual)
		begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkAddr(string name, addrT expected, addrT actual);
		if (expected !== actual)
		begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		if (expected !== actual)
		begin
			$display("FAIL %s: expected %b, actual %b", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkCount(string name, int expected, int actual);
		if (expected != actual)
		begin
			$display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
			abortRun();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////////////////////

	// Unwritten words follow the whole word address
	function automatic wordT expectedWord(addrT a);
		addrT wordAddr;
		wordAddr = a & 32'hFFFF_FFFC;
		if (memWords.exists(wordAddr))
			return memWords[wordAddr];
		return wordAddr ^ fillPattern;
	endfunction

	initial
	begin : memModel
		int   delay;
		int   guard;
		addrT a;
		memAck = 1'b0;
		memRdData = '0;
		forever
		begin
			@(negedge clk);
			if (memReq && !memAck)
			begin
				delay = $random(seed) & 3;       // 0 to 3 wait cycles
				repeat (delay) @(negedge clk);
				a = memAddr;
				if (memWe)
				begin
					memWords[a & 32'hFFFF_FFFC] = memWrData;
					lastWrAddr = a;
					lastWrData = memWrData;
					memWrites++;
				end
				else
				begin
					memRdData = expectedWord(a);
					readLog.push_back(a);
					memReads++;
				end
				memAck = 1'b1;
				guard = 0;
				while (memReq)                   // Hold ack until request drops
				begin
					@(negedge clk);
					guard++;
					if (guard > ackTimeout)
					begin
						$display("Timeout: memReq stayed high after memAck");
						abortRun();
					end
				end
				memAck = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Way holding the line, -1 on a miss
	function automatic int modelLookup(addrT a);
		cacheAddrT ca;
		ca = a;
		for (int w = 0; w < `numWays; w++)
			if (refValid[ca.index][w] && (refTag[ca.index][w] == ca.tag))
				return w;
		return -1;
	endfunction

	function automatic void markUsed(indexT s, int way);
		int used;
		used = 0;
		refUsed[s][way] = 1'b1;
		for (int w = 0; w < `numWays; w++)
			used += int'(refUsed[s][w]);
		if (used == `numWays)                  // Saturated, keep only this way
			for (int w = 0; w < `numWays; w++)
				refUsed[s][w] = (w == way);
	endfunction

	function automatic int pickVictim(indexT s);
		for (int w = 0; w < `numWays; w++)
			if (!refValid[s][w])
				return w;                      // Free way first
		for (int w = 0; w < `numWays; w++)
			if (!refUsed[s][w])
				return w;
		return 0;
	endfunction

	function automatic void allocateLine(addrT a);
		cacheAddrT ca;
		int way;
		ca = a;
		way = pickVictim(ca.index);
		refValid[ca.index][way] = 1'b1;
		refTag[ca.index][way] = ca.tag;
		markUsed(ca.index, way);
	endfunction

	function automatic addrT lineAddr(tagT t, indexT s, wordSelT w);
		cacheAddrT ca;
		ca.tag = t;
		ca.index = s;
		ca.wordSel = w;
		ca.byteOff = '0;
		return addrT'(ca);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// CPU side requests
	////////////////////////////////////////////////////////////////////////////

	task automatic waitAck(string name, logic level);
		int cycles;
		cycles = 0;
		while (cpuAck !== level)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > ackTimeout)
			begin
				$display("Timeout in %s: cpuAck did not reach %0d", name, level);
				abortRun();
			end
		end
	endtask

	task automatic cpuRead(string name, addrT a);
		cacheAddrT ca;
		int   way;
		int   readsBefore;
		int   expReads;
		wordT expData;
		wordT got;
		addrT lineBase;
		ca = a;
		way = modelLookup(a);
		expReads = (way < 0) ? `wordsPerLine : 0;
		expData = expectedWord(a);
		lineBase = a & 32'hFFFF_FFF0;
		readsBefore = memReads;
		readLog.delete();
		@(negedge clk);
		cpuAddr = a;
		cpuWe = 1'b0;
		cpuReq = 1'b1;
		waitAck(name, 1'b1);
		got = cpuRdData;                       // Valid while ack is high
		cpuReq = 1'b0;
		waitAck(name, 1'b0);
		checkCount({name, " mem reads"}, expReads, memReads - readsBefore);
		if (way < 0)
		begin
			for (int i = 0; i < `wordsPerLine; i++)
				checkAddr({name, " fill addr"}, lineBase + addrT'(4 * i), readLog[i]);
			allocateLine(a);
		end
		else
			markUsed(ca.index, way);
		checkWord(name, expData, got);
	endtask

	task automatic cpuWrite(string name, addrT a, wordT d);
		cacheAddrT ca;
		int way;
		int readsBefore;
		int writesBefore;
		ca = a;
		way = modelLookup(a);
		readsBefore = memReads;
		writesBefore = memWrites;
		@(negedge clk);
		cpuAddr = a;
		cpuWrData = d;
		cpuWe = 1'b1;
		cpuReq = 1'b1;
		waitAck(name, 1'b1);
		cpuReq = 1'b0;
		cpuWe = 1'b0;
		waitAck(name, 1'b0);
		checkCount({name, " mem writes"}, 1, memWrites - writesBefore);
		checkCount({name, " mem reads"}, 0, memReads - readsBefore);   // No allocate
		checkAddr({name, " write addr"}, a, lastWrAddr);
		checkWord({name, " write data"}, d, lastWrData);
		if (way >= 0)
			markUsed(ca.index, way);
	endtask

	task automatic cacheOp(string name, cacheOpT op, addrT a);
		cacheAddrT ca;
		int way;
		int readsBefore;
		int writesBefore;
		ca = a;
		way = modelLookup(a);
		readsBefore = memReads;
		writesBefore = memWrites;
		@(negedge clk);
		cpuAddr = a;
		opCode = op;
		opReq = 1'b1;
		waitAck(name, 1'b1);
		opReq = 1'b0;
		waitAck(name, 1'b0);
		checkCount({name, " mem reads"}, 0, memReads - readsBefore);
		checkCount({name, " mem writes"}, 0, memWrites - writesBefore);
		if ((op == opInvalLine) && (way >= 0))
			refValid[ca.index][way] = 1'b0;    // Used bits stay as they are
		else if (op == opInvalAll)
			for (int s = 0; s < numSets; s++)
				for (int w = 0; w < `numWays; w++)
					refValid[s][w] = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic resetState();
		checkFlag("reset cpuAck", 1'b0, cpuAck);
		checkFlag("reset memReq", 1'b0, memReq);
		checkFlag("reset memWe", 1'b0, memWe);
		checkWord("reset cpuRdData", '0, cpuRdData);
		cpuRead("reset first read", 32'h0000_1234);           // Cold cache misses
	endtask

	task automatic readMissThenHit();
		cpuRead("read miss", 32'h0001_0A48);
		cpuRead("read hit", 32'h0001_0A48);                   // No memory access
	endtask

	task automatic writeThrough();
		cpuWrite("write hit", 32'h0001_0A44, 32'hDEAD_BEEF);
		cpuRead("read after write hit", 32'h0001_0A44);
		cpuWrite("write miss", 32'h0002_2200, 32'h1234_5678);
		cpuRead("read after write miss", 32'h0002_2200);     // Fill brings written word
	endtask

	task automatic replaceInSet();
		indexT s;
		s = 8'h5C;
		for (int i = 0; i < 3; i++)
			cpuRead($sformatf("replace fill %0d", i), lineAddr(tagT'(20'h100 + i), s, '0));
		cpuRead("replace fill 3", lineAddr(20'h00103, s, 2'd2));
		cpuRead("replace touch", lineAddr(20'h00100, s, 2'd1)); // Way 0 survives next fill
		cpuRead("replace fill 4", lineAddr(20'h00104, s, 2'd3)); // Set full, evicts
		for (int i = 0; i < 5; i++)
			cpuRead($sformatf("replace check %0d", i),
				lineAddr(tagT'(20'h100 + i), s, wordSelT'(i)));
	endtask

	task automatic invalidateLine();
		indexT s;
		s = 8'h5C;
		cacheOp("inval line", opInvalLine, lineAddr(20'h00103, s, '0));
		cpuRead("inval neighbour 0", lineAddr(20'h00102, s, '0));
		cpuRead("inval neighbour 1", lineAddr(20'h00104, s, '0));
		cpuRead("inval neighbour 2", lineAddr(20'h00101, s, '0));
		cpuRead("inval dropped line", lineAddr(20'h00103, s, '0));
		cacheOp("inval uncached", opInvalLine, lineAddr(20'hABCDE, s, '0));
		cpuRead("inval uncached after", lineAddr(20'h00102, s, 2'd1));
	endtask

	task automatic invalidateAll();
		cacheOp("inval all", opInvalAll, '0);
		cpuRead("flush 0", 32'h0001_0A48);
		cpuRead("flush 1", 32'h0002_2200);
		cpuRead("flush 2", 32'h0000_1234);
		cpuRead("flush 3", lineAddr(20'h00102, 8'h5C, '0));
		cacheOp("op 2", cacheOpT'(`opCodeWidth'(2)), 32'h0001_0A48);  // Ack only
		cpuRead("after op 2", 32'h0001_0A48);
	endtask

	initial
	begin
		rstN = 1'b0;
		cpuReq = 1'b0;
		cpuWe = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		opReq = 1'b0;
		opCode = opNone;
		memReads = 0;
		memWrites = 0;
		repeat (8) @(negedge clk);             // Reset for 8 cycles
		rstN = 1'b1;
		@(negedge clk);
		resetState();
		readMissThenHit();
		writeThrough();
		replaceInSet();
		invalidateLine();
		invalidateAll();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== cacheL1.f ====
+incdir+.
busPkg.sv
cachePkg.sv
cacheIfc.sv
cacheTagStore.sv
cacheDataStore.sv
cacheController.sv
cacheL1.sv
cacheL1_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cacheL1_tb
FILELIST  ?= cacheL1.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
